//--- Bender.yml
package:
  name: execute_subsystem

sources:
  - source/rv_isa_pkg.sv
  - source/exec_pkg.sv
  - source/arith_logic_unit.sv
  - source/branch_unit.sv
  - source/execute_stage.sv
  - source/result_fifo.sv
  - source/retire_stage.sv
  - source/execute_subsystem.sv
  - target: test
    files:
      - test/exec_checker.sv
      - test/tb_execute.sv

//--- all.f
source/rv_isa_pkg.sv
source/exec_pkg.sv
source/arith_logic_unit.sv
source/branch_unit.sv
source/execute_stage.sv
source/result_fifo.sv
source/retire_stage.sv
source/execute_subsystem.sv
test/exec_checker.sv
test/tb_execute.sv

//--- source/arith_logic_unit.sv
`timescale 1ns/10ps
`default_nettype none

module arith_logic_unit (
    input   logic [31:0]              first_operand_i,
    input   logic [31:0]              second_operand_i,
    input   rv_isa_pkg::exec_unit_e   unit_i,
    input   rv_isa_pkg::op_type_e     operation_i,
    output  logic [31:0]              result_o
);

    logic [31:0] adder_result;
    logic [31:0] logic_result;
    logic [31:0] shift_result;
    logic [4:0]  shift_amount;

    assign shift_amount = second_operand_i[4:0];   // Only the low five bits count

    always_comb begin
        case (operation_i)
            rv_isa_pkg::OP_SUB:  adder_result = first_operand_i - second_operand_i;
            rv_isa_pkg::OP_SLT:  adder_result = {31'b0, $signed(first_operand_i)
                                                        < $signed(second_operand_i)};
            rv_isa_pkg::OP_SLTU: adder_result = {31'b0, first_operand_i < second_operand_i};
            default:             adder_result = first_operand_i + second_operand_i;
        endcase
    end

    always_comb begin
        case (operation_i)
            rv_isa_pkg::OP_OR:  logic_result = first_operand_i | second_operand_i;
            rv_isa_pkg::OP_AND: logic_result = first_operand_i & second_operand_i;
            default:            logic_result = first_operand_i ^ second_operand_i;
        endcase
    end

    always_comb begin
        case (operation_i)
            rv_isa_pkg::OP_SRL: shift_result = first_operand_i >> shift_amount;
            rv_isa_pkg::OP_SRA: shift_result = $signed(first_operand_i) >>> shift_amount;
            default:            shift_result = first_operand_i << shift_amount;
        endcase
    end

    // Pick the unit that owns this operation
    always_comb begin
        case (unit_i)
            rv_isa_pkg::ADDER_UNIT:   result_o = adder_result;
            rv_isa_pkg::LOGICAL_UNIT: result_o = logic_result;
            rv_isa_pkg::SHIFTER_UNIT: result_o = shift_result;
            default:                  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input   logic [31:0]            first_operand_i,
    input   logic [31:0]            second_operand_i,
    input   logic [31:0]            offset_i,
    input   logic [31:0]            pc_i,
    input   rv_isa_pkg::op_type_e   operation_i,
    output  logic [31:0]            target_o,
    output  logic [31:0]            link_o,
    output  logic                   jump_o,
    output  logic                   write_enable_o
);

    logic equal;
    logic less_signed;
    logic less_unsigned;
    logic is_jal;
    logic is_jalr;

    assign equal         = first_operand_i == second_operand_i;
    assign less_signed   = $signed(first_operand_i) < $signed(second_operand_i);
    assign less_unsigned = first_operand_i < second_operand_i;
    assign is_jal        = operation_i == rv_isa_pkg::OP_JAL;
    assign is_jalr       = operation_i == rv_isa_pkg::OP_JALR;

    always_comb begin
        case (operation_i)
            rv_isa_pkg::OP_BEQ:  jump_o = equal;
            rv_isa_pkg::OP_BNE:  jump_o = !equal;
            rv_isa_pkg::OP_BLT:  jump_o = less_signed;
            rv_isa_pkg::OP_BGE:  jump_o = !less_signed;
            rv_isa_pkg::OP_BLTU: jump_o = less_unsigned;
            rv_isa_pkg::OP_BGEU: jump_o = !less_unsigned;
            default:             jump_o = 1'b1;     // JAL and JALR always jump
        endcase
    end

    // JALR is register relative, with bit 0 forced low
    assign target_o = is_jalr ? ((first_operand_i + offset_i) & ~32'd1)
                              : (pc_i + offset_i);

    assign link_o         = pc_i + 32'd4;          // Return address
    assign write_enable_o = is_jal || is_jalr;

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int TAG_WIDTH = 3;

    //////////////////////////////////////////////////////////////////////////
    // Packets along the execute path
    //////////////////////////////////////////////////////////////////////////

    // From operand fetch
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::i_type_e   operation;
        logic [31:0]           pc;
        logic [31:0]           first_operand;
        logic [31:0]           second_operand;
        logic [31:0]           third_operand;   // Branch offset
        logic [4:0]            rd;
        logic [TAG_WIDTH-1:0]  tag;
    } issue_t;

    // Registered by execute, queued in the result FIFO
    typedef struct packed {
        logic [31:0]           result;          // Value for rd
        logic [31:0]           target;          // Jump target
        logic                  jump;
        logic                  write_enable;
        logic [4:0]            rd;
        logic [TAG_WIDTH-1:0]  tag;
    } result_t;

    // Report of one retired instruction
    typedef struct packed {
        logic                  valid;
        logic [4:0]            rd;
        logic [31:0]           value;           // Content of rd after retirement
        logic                  write_enable;
    } retire_t;

endpackage

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input   logic                clk,
    input   logic                rst_n_i,
    input   exec_pkg::issue_t    issue_i,
    input   logic                stall_i,
    output  exec_pkg::result_t   result_o,
    output  logic                result_valid_o
);

    rv_isa_pkg::exec_unit_e   unit;
    rv_isa_pkg::op_type_e     sub_operation;

    logic [31:0]          alu_result;
    logic [31:0]          branch_target;
    logic [31:0]          branch_link;
    logic                 branch_jump;
    logic                 branch_write_enable;
    exec_pkg::result_t    result_next;

    assign unit          = rv_isa_pkg::exec_unit_e'(issue_i.operation[5:3]);
    assign sub_operation = issue_i.operation[2:0];

    ////////////////////////////////////////////////////////////////////////////
    // Execution units
    ////////////////////////////////////////////////////////////////////////////

    arith_logic_unit alu_inst (
        .first_operand_i    (issue_i.first_operand),
        .second_operand_i   (issue_i.second_operand),
        .unit_i             (unit),
        .operation_i        (sub_operation),
        .result_o           (alu_result)
    );

    branch_unit branch_inst (
        .first_operand_i    (issue_i.first_operand),
        .second_operand_i   (issue_i.second_operand),
        .offset_i           (issue_i.third_operand),
        .pc_i               (issue_i.pc),
        .operation_i        (sub_operation),
        .target_o           (branch_target),
        .link_o             (branch_link),
        .jump_o             (branch_jump),
        .write_enable_o     (branch_write_enable)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        result_next.rd  = issue_i.rd;
        result_next.tag = issue_i.tag;
        if (unit == rv_isa_pkg::BRANCH_UNIT) begin
            result_next.result       = branch_link;
            result_next.target       = branch_target;
            result_next.jump         = branch_jump;
            result_next.write_enable = branch_write_enable;
        end
        else begin
            // Bypass hands the second operand straight through
            result_next.result       = (unit == rv_isa_pkg::BYPASS_UNIT)
                                       ? issue_i.second_operand : alu_result;
            result_next.target       = '0;
            result_next.jump         = 1'b0;
            result_next.write_enable = issue_i.operation != rv_isa_pkg::NOP;
        end
    end

    // Payload holds under stall
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result_next;
        end
    end

    // Valid lasts one cycle, the held entry is already in the FIFO
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
        end
        else begin
            result_valid_o <= issue_i.valid && !stall_i;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module execute_subsystem #(
    parameter int FIFO_DEPTH = 4
) (
    input   logic                            clk,
    input   logic                            rst_n_i,
    input   exec_pkg::issue_t                issue_i,
    input   logic                            retire_ready_i,
    output  logic                            stall_o,
    output  exec_pkg::retire_t               retire_o,
    output  logic                            jump_o,
    output  logic [31:0]                     jump_target_o,
    output  logic [exec_pkg::TAG_WIDTH-1:0]  current_tag_o
);

    exec_pkg::result_t   exec_result;
    logic                exec_valid;
    exec_pkg::result_t   fifo_head;
    logic                fifo_not_empty;
    logic                pop;

    execute_stage execute_stage_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_i         (issue_i),
        .stall_i         (stall_o),
        .result_o        (exec_result),
        .result_valid_o  (exec_valid)
    );

    result_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .payload_t  (exec_pkg::result_t)
    ) result_fifo_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_i       (exec_valid),
        .data_i       (exec_result),
        .pop_i        (pop),
        .data_o       (fifo_head),
        .not_empty_o  (fifo_not_empty),
        .stall_o      (stall_o)
    );

    retire_stage retire_stage_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head_i         (fifo_head),
        .not_empty_i    (fifo_not_empty),
        .ready_i        (retire_ready_i),
        .pop_o          (pop),
        .retire_o       (retire_o),
        .jump_o         (jump_o),
        .jump_target_o  (jump_target_o),
        .current_tag_o  (current_tag_o)
    );

endmodule

`default_nettype wire

//--- source/result_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module result_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [31:0]
) (
    input   logic       clk,
    input   logic       rst_n_i,
    input   logic       push_i,
    input   payload_t   data_i,
    input   logic       pop_i,
    output  payload_t   data_o,
    output  logic       not_empty_o,
    output  logic       stall_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    assign do_pop = pop_i && not_empty_o;

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle or push with pop
            endcase
        end
    end

    assign data_o      = mem[rd_ptr];
    assign not_empty_o = count != '0;

    // One slot kept free for the entry still in the execute register
    assign stall_o = count >= CNT_W'(DEPTH - 1);

endmodule

`default_nettype wire

//--- source/retire_stage.sv
`timescale 1ns/10ps
`default_nettype none

module retire_stage (
    input   logic                                clk,
    input   logic                                rst_n_i,
    input   exec_pkg::result_t                   head_i,
    input   logic                                not_empty_i,
    input   logic                                ready_i,
    output  logic                                pop_o,
    output  exec_pkg::retire_t                   retire_o,
    output  logic                                jump_o,
    output  logic [31:0]                         jump_target_o,
    output  logic [exec_pkg::TAG_WIDTH-1:0]      current_tag_o
);

    logic [31:0]                     reg_bank [32];
    logic [exec_pkg::TAG_WIDTH-1:0]  current_tag;
    logic                            accept;
    logic                            bank_write;

    assign pop_o         = not_empty_i && ready_i;
    assign accept        = pop_o && (head_i.tag == current_tag);   // Wrong path dropped
    assign bank_write    = accept && head_i.write_enable && (head_i.rd != 5'd0);
    assign current_tag_o = current_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Register bank, x0 never written
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                reg_bank[i] <= '0;
            end
        end
        else if (bank_write) begin
            reg_bank[head_i.rd] <= head_i.result;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retire report and redirect
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_o.valid <= 1'b0;
            jump_o         <= 1'b0;
            current_tag    <= '0;
        end
        else begin
            retire_o.valid <= accept;
            jump_o         <= accept && head_i.jump;
            if (accept) begin
                retire_o.rd           <= head_i.rd;
                retire_o.write_enable <= head_i.write_enable;
                // Value rd holds once this retirement is done
                retire_o.value        <= bank_write ? head_i.result : reg_bank[head_i.rd];
            end
            if (accept && head_i.jump) begin
                jump_target_o <= head_i.target;
                current_tag   <= current_tag + 1'b1;     // Kills older tags
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    //////////////////////////////////////////////////////////////////////////
    // Execution units, upper three bits of an operation
    //////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ADDER_UNIT   = 3'd0,
        LOGICAL_UNIT = 3'd1,
        SHIFTER_UNIT = 3'd2,
        BRANCH_UNIT  = 3'd3,
        BYPASS_UNIT  = 3'd4
    } exec_unit_e;

    // Sub-operation codes repeat from unit to unit
    typedef logic [2:0] op_type_e;

    localparam op_type_e OP_ADD    = 3'd0;
    localparam op_type_e OP_SUB    = 3'd1;
    localparam op_type_e OP_SLT    = 3'd2;
    localparam op_type_e OP_SLTU   = 3'd3;
    localparam op_type_e OP_XOR    = 3'd0;
    localparam op_type_e OP_OR     = 3'd1;
    localparam op_type_e OP_AND    = 3'd2;
    localparam op_type_e OP_SLL    = 3'd0;
    localparam op_type_e OP_SRL    = 3'd1;
    localparam op_type_e OP_SRA    = 3'd2;
    localparam op_type_e OP_BEQ    = 3'd0;
    localparam op_type_e OP_BNE    = 3'd1;
    localparam op_type_e OP_BLT    = 3'd2;
    localparam op_type_e OP_BGE    = 3'd3;
    localparam op_type_e OP_BLTU   = 3'd4;
    localparam op_type_e OP_BGEU   = 3'd5;
    localparam op_type_e OP_JAL    = 3'd6;
    localparam op_type_e OP_JALR   = 3'd7;
    localparam op_type_e OP_BYPASS = 3'd0;
    localparam op_type_e OP_NOP    = 3'd1;

    //////////////////////////////////////////////////////////////////////////
    // Full operation, {unit, sub-operation}
    //////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        ADD  = 6'o00, SUB  = 6'o01, SLT  = 6'o02, SLTU = 6'o03,
        XOR  = 6'o10, OR   = 6'o11, AND  = 6'o12,
        SLL  = 6'o20, SRL  = 6'o21, SRA  = 6'o22,
        BEQ  = 6'o30, BNE  = 6'o31, BLT  = 6'o32, BGE  = 6'o33,
        BLTU = 6'o34, BGEU = 6'o35, JAL  = 6'o36, JALR = 6'o37,
        BYPASS = 6'o40,
        NOP    = 6'o41
    } i_type_e;

endpackage

`default_nettype wire

//--- test/exec_checker.sv
`timescale 1ns/10ps
`default_nettype none

module exec_checker (
    input   logic                            clk,
    input   logic                            rst_n_i,
    input   exec_pkg::issue_t                issue_i,
    input   logic                            stall_i,
    input   exec_pkg::retire_t               retire_i,
    input   logic                            jump_i,
    input   logic [31:0]                     jump_target_i,
    input   logic [exec_pkg::TAG_WIDTH-1:0]  current_tag_i,
    output  int                              value_errors_o,
    output  int                              order_errors_o,
    output  int                              live_count_o
);

    exec_pkg::result_t               expected_q [$];   // Accepted work in program order
    logic [31:0]                     model_bank [32];
    logic [exec_pkg::TAG_WIDTH-1:0]  model_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of one instruction
    ////////////////////////////////////////////////////////////////////////////

    function automatic exec_pkg::result_t model_execute(exec_pkg::issue_t iss);
        exec_pkg::result_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        a              = iss.first_operand;
        b              = iss.second_operand;
        taken          = 1'b0;
        r.rd           = iss.rd;
        r.tag          = iss.tag;
        r.target       = iss.pc + iss.third_operand;
        r.jump         = 1'b0;
        r.write_enable = 1'b1;
        r.result       = b;                             // Bypass value
        case (iss.operation)
            rv_isa_pkg::ADD:  r.result = a + b;
            rv_isa_pkg::SUB:  r.result = a - b;
            rv_isa_pkg::SLT:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::SLTU: r.result = (a < b) ? 32'd1 : 32'd0;
            rv_isa_pkg::XOR:  r.result = a ^ b;
            rv_isa_pkg::OR:   r.result = a | b;
            rv_isa_pkg::AND:  r.result = a & b;
            rv_isa_pkg::SLL:  r.result = a << b[4:0];
            rv_isa_pkg::SRL:  r.result = a >> b[4:0];
            rv_isa_pkg::SRA:  r.result = $signed(a) >>> b[4:0];
            rv_isa_pkg::NOP:  r.write_enable = 1'b0;
            rv_isa_pkg::BEQ:  taken = a == b;
            rv_isa_pkg::BNE:  taken = a != b;
            rv_isa_pkg::BLT:  taken = $signed(a) < $signed(b);
            rv_isa_pkg::BGE:  taken = $signed(a) >= $signed(b);
            rv_isa_pkg::BLTU: taken = a < b;
            rv_isa_pkg::BGEU: taken = a >= b;
            rv_isa_pkg::JAL:  taken = 1'b1;
            rv_isa_pkg::JALR: begin
                taken    = 1'b1;
                r.target = (a + iss.third_operand) & ~32'd1;   // Bit 0 cleared
            end
            default:          r.result = b;
        endcase
        if (iss.operation[5:3] == 3'd3) begin           // Branch unit
            r.result       = iss.pc + 32'd4;
            r.jump         = taken;
            r.write_enable = (iss.operation == rv_isa_pkg::JAL)
                          || (iss.operation == rv_isa_pkg::JALR);
        end
        return r;
    endfunction

    // Entries that should still retire under the model's tag
    function automatic int count_live();
        logic [exec_pkg::TAG_WIDTH-1:0] t;
        int n;
        t = model_tag;
        n = 0;
        foreach (expected_q[i]) begin
            if (expected_q[i].tag == t) begin
                n++;
                if (expected_q[i].jump) t++;
            end
        end
        return n;
    endfunction

    task automatic check_retirement();
        exec_pkg::result_t exp;
        logic [31:0]       exp_value;
        while (expected_q.size() > 0 && expected_q[0].tag != model_tag) begin
            void'(expected_q.pop_front());              // Wrong path, silently killed
        end
        if (expected_q.size() == 0) begin
            order_errors_o++;
            $display("Extra retirement of rd %0d at %0t with nothing expected",
                     retire_i.rd, $time);
            return;
        end
        exp       = expected_q.pop_front();
        exp_value = (exp.write_enable && exp.rd != 0) ? exp.result : model_bank[exp.rd];
        if (retire_i.rd !== exp.rd || retire_i.write_enable !== exp.write_enable
                || retire_i.value !== exp_value) begin
            value_errors_o++;
            $display("FAILED %0t: retire rd %0d we %0b value %h, expected rd %0d we %0b value %h",
                     $time, retire_i.rd, retire_i.write_enable, retire_i.value,
                     exp.rd, exp.write_enable, exp_value);
        end
        if (jump_i !== exp.jump || (exp.jump && jump_target_i !== exp.target)) begin
            value_errors_o++;
            $display("FAILED %0t: jump %0b target %h, expected jump %0b target %h",
                     $time, jump_i, jump_target_i, exp.jump, exp.target);
        end
        if (exp.write_enable && exp.rd != 0) model_bank[exp.rd] = exp.result;
        if (exp.jump) model_tag++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sampling
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n_i && issue_i.valid && !stall_i) begin
            expected_q.push_back(model_execute(issue_i));   // Accepted this edge
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            expected_q.delete();
            model_tag      = '0;
            value_errors_o = 0;
            order_errors_o = 0;
            foreach (model_bank[i]) model_bank[i] = '0;
        end
        else begin
            if (retire_i.valid) begin
                check_retirement();
            end
            else if (jump_i) begin
                order_errors_o++;
                $display("Jump pulse at %0t without a retirement", $time);
            end
            if (current_tag_i !== model_tag) begin          // Tag seen by fetch
                value_errors_o++;
                $display("FAILED %0t: current tag %0d, expected %0d",
                         $time, current_tag_i, model_tag);
            end
        end
        live_count_o = count_live();
    end

endmodule

`default_nettype wire

//--- test/tb_execute.sv
`timescale 1ns/10ps
`default_nettype none

module tb_execute;

    localparam int PERIOD = 40;
    localparam int ROWS   = 30;

    typedef struct packed {
        rv_isa_pkg::i_type_e  op;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          c;                        // Branch offset
        logic [31:0]          pc;
        logic [4:0]           rd;
        logic                 stale;                    // Tag one behind current
    } row_t;

    localparam row_t STIMULUS [ROWS] = '{
        '{rv_isa_pkg::ADD,    32'd5,        32'd7,        32'd0,    32'h100, 5'd1,  1'b0},
        '{rv_isa_pkg::SUB,    32'd3,        32'd10,       32'd0,    32'h104, 5'd2,  1'b0},
        '{rv_isa_pkg::SLT,    32'hffffffff, 32'd1,        32'd0,    32'h108, 5'd3,  1'b0},
        '{rv_isa_pkg::SLTU,   32'hffffffff, 32'd1,        32'd0,    32'h10c, 5'd4,  1'b0},
        '{rv_isa_pkg::XOR,    32'h0f0f00ff, 32'h00ff0f0f, 32'd0,    32'h110, 5'd5,  1'b0},
        '{rv_isa_pkg::OR,     32'h12340000, 32'h00005678, 32'd0,    32'h114, 5'd6,  1'b0},
        '{rv_isa_pkg::AND,    32'hf0f0f0f0, 32'h3c3c3c3c, 32'd0,    32'h118, 5'd7,  1'b0},
        '{rv_isa_pkg::SLL,    32'd1,        32'd35,       32'd0,    32'h11c, 5'd8,  1'b0},
        '{rv_isa_pkg::SRL,    32'h80000000, 32'd4,        32'd0,    32'h120, 5'd9,  1'b0},
        '{rv_isa_pkg::SRA,    32'h80000000, 32'd4,        32'd0,    32'h124, 5'd10, 1'b0},
        '{rv_isa_pkg::BYPASS, 32'd0,        32'hdeadbeef, 32'd0,    32'h128, 5'd11, 1'b0},
        '{rv_isa_pkg::NOP,    32'd9,        32'd9,        32'd0,    32'h12c, 5'd1,  1'b0},
        '{rv_isa_pkg::ADD,    32'd40,       32'd2,        32'd0,    32'h130, 5'd0,  1'b0},
        '{rv_isa_pkg::BEQ,    32'd4,        32'd4,        32'h20,   32'h134, 5'd12, 1'b0},
        '{rv_isa_pkg::ADD,    32'd1,        32'd1,        32'd0,    32'h138, 5'd13, 1'b1},
        '{rv_isa_pkg::ADD,    32'd2,        32'd2,        32'd0,    32'h154, 5'd14, 1'b0},
        '{rv_isa_pkg::BNE,    32'd4,        32'd4,        32'h40,   32'h158, 5'd15, 1'b0},
        '{rv_isa_pkg::XOR,    32'd6,        32'd3,        32'd0,    32'h15c, 5'd16, 1'b0},
        '{rv_isa_pkg::JAL,    32'd0,        32'd0,        32'h40,   32'h200, 5'd17, 1'b0},
        '{rv_isa_pkg::SUB,    32'd8,        32'd1,        32'd0,    32'h204, 5'd18, 1'b1},
        '{rv_isa_pkg::OR,     32'd8,        32'd1,        32'd0,    32'h240, 5'd19, 1'b0},
        '{rv_isa_pkg::JALR,   32'h1001,     32'd0,        32'h10,   32'h244, 5'd20, 1'b0},
        '{rv_isa_pkg::AND,    32'd7,        32'd3,        32'd0,    32'h248, 5'd21, 1'b1},
        '{rv_isa_pkg::BLT,    32'hfffffff0, 32'd1,        32'h8,    32'h1010, 5'd22, 1'b0},
        '{rv_isa_pkg::BGE,    32'hfffffff0, 32'd1,        32'h8,    32'h1018, 5'd23, 1'b0},
        '{rv_isa_pkg::BLTU,   32'hfffffff0, 32'd1,        32'h8,    32'h101c, 5'd24, 1'b0},
        '{rv_isa_pkg::BGEU,   32'hfffffff0, 32'd1,        32'hc,    32'h1020, 5'd25, 1'b0},
        '{rv_isa_pkg::SLL,    32'h3,        32'd4,        32'd0,    32'h102c, 5'd26, 1'b0},
        '{rv_isa_pkg::ADD,    32'd100,      32'd23,       32'd0,    32'h1030, 5'd1,  1'b0},
        '{rv_isa_pkg::SRA,    32'h7000000f, 32'd2,        32'd0,    32'h1034, 5'd27, 1'b0}
    };

    logic                            clk;
    logic                            rst_n_i;
    exec_pkg::issue_t                issue_i;
    logic                            retire_ready_i;
    logic                            stall_o;
    exec_pkg::retire_t               retire_o;
    logic                            jump_o;
    logic [31:0]                     jump_target_o;
    logic [exec_pkg::TAG_WIDTH-1:0]  current_tag_o;
    logic [15:0]                     lfsr_state;
    logic                            ready_bit0;
    logic                            ready_bit1;
    int                              value_errors;
    int                              order_errors;
    int                              live_count;

    execute_subsystem #(
        .FIFO_DEPTH  (4)
    ) execute_subsystem_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_i         (issue_i),
        .retire_ready_i  (retire_ready_i),
        .stall_o         (stall_o),
        .retire_o        (retire_o),
        .jump_o          (jump_o),
        .jump_target_o   (jump_target_o),
        .current_tag_o   (current_tag_o)
    );

    exec_checker checker_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_i         (issue_i),
        .stall_i         (stall_o),
        .retire_i        (retire_o),
        .jump_i          (jump_o),
        .jump_target_i   (jump_target_o),
        .current_tag_i   (current_tag_o),
        .value_errors_o  (value_errors),
        .order_errors_o  (order_errors),
        .live_count_o    (live_count)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic exec_pkg::issue_t make_issue(input row_t row);
        exec_pkg::issue_t iss;
        iss.valid          = 1'b1;
        iss.operation      = row.op;
        iss.pc             = row.pc;
        iss.first_operand  = row.a;
        iss.second_operand = row.b;
        iss.third_operand  = row.c;
        iss.rd             = row.rd;
        iss.tag            = row.stale ? current_tag_o - 1'b1 : current_tag_o;
        return iss;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Retire ready low about a quarter of the time
    always @(posedge clk) begin
        if (!rst_n_i) begin
            retire_ready_i <= 1'b0;
        end
        else begin
            ready_bit0      = lfsr_state[15];
            lfsr_state      = lfsr_next(lfsr_state);
            ready_bit1      = lfsr_state[15];
            lfsr_state      = lfsr_next(lfsr_state);
            retire_ready_i <= ready_bit0 | ready_bit1;
        end
    end

    initial begin
        #(PERIOD * (ROWS * 8 + 50));
        $display("Watchdog timeout, %0d expected retirements never arrived", live_count);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n_i        = 1'b0;
        issue_i        = '0;
        retire_ready_i = 1'b0;
        lfsr_state     = 16'd16;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            issue_i <= make_issue(STIMULUS[i]);
            do @(posedge clk); while (stall_o);          // Held until accepted
            if (STIMULUS[i].op[5:3] == rv_isa_pkg::BRANCH_UNIT) begin
                issue_i <= '0;                           // Fetch waits for the redirect
                @(posedge clk);
                while (live_count != 0) @(posedge clk);
            end
        end
        issue_i <= '0;
        repeat (2) @(posedge clk);
        while (live_count != 0) @(posedge clk);
        repeat (10) @(posedge clk);                      // Room for any extra retirement
        $display("Checks done with %0d value errors and %0d order errors",
                 value_errors, order_errors);
        if (value_errors == 0 && order_errors == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
